// ==== hdl/mem_test_pkg.sv ====
package mem_test_pkg;

    localparam int DATA_WIDTH   = 16;
    localparam int ADDR_WIDTH   = 7;
    localparam int DATA_BYTES   = 2;  // bytes per data field in a frame.
    localparam int CLKS_PER_BIT = 4;

    localparam logic [7:0] PHASE_FILL      = 8'd1;
    localparam logic [7:0] PHASE_READ_ZERO = 8'd2;
    localparam logic [7:0] PHASE_READ_ONE  = 8'd3;

    localparam logic [7:0] CH_ERROR = "E";
    localparam logic [7:0] CH_LOOP  = "L";
    localparam logic [7:0] CH_CR    = 8'h0d;
    localparam logic [7:0] CH_LF    = 8'h0a;

    // one memory access, held stable for the whole handshake.
    typedef struct packed {
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } mem_cmd_t;

    // one failed compare.
    typedef struct packed {
        logic [7:0]            phase;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] expected;
        logic [DATA_WIDTH-1:0] actual;
    } error_rec_t;

endpackage

// ==== hdl/march_sequencer.sv ====
`timescale 1ns/1ps

module march_sequencer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                run,
    output logic                                mem_req,
    output mem_test_pkg::mem_cmd_t              mem_cmd,
    input  logic                                mem_ack,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0] mem_rdata,
    output logic                                error_event,
    output mem_test_pkg::error_rec_t            error_rec,
    output logic                                loop_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_RELEASE
    } state_t;

    state_t                              state;
    logic [7:0]                          phase;
    logic [mem_test_pkg::ADDR_WIDTH-1:0] addr;
    logic                                wr_step;  // write half of a phase-2 word.
    logic [mem_test_pkg::DATA_WIDTH-1:0] expected;
    logic                                mismatch;

    // command follows the march position, which only moves on ack.
    always_comb begin
        mem_cmd.we    = (phase == mem_test_pkg::PHASE_FILL) || wr_step;
        mem_cmd.addr  = addr;
        mem_cmd.wdata = (phase == mem_test_pkg::PHASE_FILL) ? '0 : '1;
        expected      = (phase == mem_test_pkg::PHASE_READ_ONE) ? '1 : '0;
        mismatch      = !mem_cmd.we && (mem_rdata != expected);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            mem_req     <= 1'b0;
            phase       <= mem_test_pkg::PHASE_FILL;
            addr        <= '0;
            wr_step     <= 1'b0;
            error_event <= 1'b0;
            loop_done   <= 1'b0;
        end else begin
            error_event <= 1'b0;
            loop_done   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (run) begin
                        mem_req <= 1'b1;
                        state   <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (mem_ack) begin
                        mem_req     <= 1'b0;
                        state       <= S_RELEASE;
                        error_event <= mismatch;
                        if (phase == mem_test_pkg::PHASE_READ_ZERO && !wr_step) begin
                            wr_step <= 1'b1;  // same word, now write ones.
                        end else begin
                            wr_step <= 1'b0;
                            addr    <= addr + 1'b1;  // wraps at the top.
                            if (addr == '1) begin
                                case (phase)
                                    mem_test_pkg::PHASE_FILL: begin
                                        phase <= mem_test_pkg::PHASE_READ_ZERO;
                                    end
                                    mem_test_pkg::PHASE_READ_ZERO: begin
                                        phase <= mem_test_pkg::PHASE_READ_ONE;
                                    end
                                    default: begin
                                        phase     <= mem_test_pkg::PHASE_FILL;
                                        loop_done <= 1'b1;
                                    end
                                endcase
                            end
                        end
                    end
                end
                S_RELEASE: begin
                    if (!mem_ack) begin
                        if (run) begin
                            mem_req <= 1'b1;
                            state   <= S_REQ;
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_REQ && mem_ack) begin
            error_rec.phase    <= phase;
            error_rec.addr     <= addr;
            error_rec.expected <= expected;
            error_rec.actual   <= mem_rdata;
        end
    end

endmodule

// ==== hdl/error_report.sv ====
`timescale 1ns/1ps

module error_report (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     error_event,
    input  mem_test_pkg::error_rec_t error_rec,
    input  logic                     loop_done,
    input  logic                     tx_accepted,
    output logic                     tx_valid,
    output logic [7:0]               tx_byte
);

    typedef enum logic [9:0] {
        F_IDLE  = 10'b00_0000_0001,
        F_E_HDR = 10'b00_0000_0010,
        F_E_PH  = 10'b00_0000_0100,
        F_E_ADR = 10'b00_0000_1000,
        F_E_EXP = 10'b00_0001_0000,
        F_E_ACT = 10'b00_0010_0000,
        F_L_HDR = 10'b00_0100_0000,
        F_L_CNT = 10'b00_1000_0000,
        F_L_CR  = 10'b01_0000_0000,
        F_L_LF  = 10'b10_0000_0000
    } frame_t;

    frame_t                                      state;
    mem_test_pkg::error_rec_t                    rec_q;
    logic                                        rec_valid;
    logic [7:0]                                  err_cnt;
    logic [7:0]                                  cnt_next;
    logic [7:0]                                  loop_cnt;
    logic                                        loop_pend;
    logic [$clog2(mem_test_pkg::DATA_BYTES)-1:0] byte_idx;
    logic                                        byte_last;

    // an error in the loop_done cycle still counts for that loop.
    assign cnt_next  = (error_event && err_cnt != 8'hff) ? err_cnt + 8'd1 : err_cnt;
    assign byte_last = (32'(byte_idx) == mem_test_pkg::DATA_BYTES - 1);

    always_ff @(posedge clk) begin
        if (error_event && !rec_valid) begin
            rec_q <= error_rec;
        end
        if (loop_done && !loop_pend) begin
            loop_cnt <= cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= F_IDLE;
            rec_valid <= 1'b0;
            err_cnt   <= 8'd0;
            loop_pend <= 1'b0;
            byte_idx  <= '0;
            tx_valid  <= 1'b0;
        end else begin
            if (error_event && !rec_valid) begin
                rec_valid <= 1'b1;
            end
            if (loop_done) begin
                loop_pend <= 1'b1;
                err_cnt   <= 8'd0;
            end else begin
                err_cnt <= cnt_next;
            end
            if (tx_accepted) begin
                tx_valid <= 1'b0;
            end

            case (state)
                F_IDLE: begin
                    if (rec_valid) begin
                        state <= F_E_HDR;  // errors go first.
                    end else if (loop_pend) begin
                        state <= F_L_HDR;
                    end
                end
                F_E_HDR: begin
                    if (!tx_valid) begin
                        tx_byte  <= mem_test_pkg::CH_ERROR;
                        tx_valid <= 1'b1;
                        byte_idx <= '0;
                        state    <= F_E_PH;
                    end
                end
                F_E_PH: begin
                    if (!tx_valid) begin
                        tx_byte  <= rec_q.phase;
                        tx_valid <= 1'b1;
                        state    <= F_E_ADR;
                    end
                end
                F_E_ADR: begin
                    if (!tx_valid) begin
                        tx_byte  <= 8'(rec_q.addr);
                        tx_valid <= 1'b1;
                        state    <= F_E_EXP;
                    end
                end
                F_E_EXP: begin
                    if (!tx_valid) begin
                        tx_byte  <= rec_q.expected[8*byte_idx +: 8];  // lsb first.
                        tx_valid <= 1'b1;
                        byte_idx <= byte_last ? '0 : byte_idx + 1'b1;
                        if (byte_last) begin
                            state <= F_E_ACT;
                        end
                    end
                end
                F_E_ACT: begin
                    if (!tx_valid) begin
                        tx_byte  <= rec_q.actual[8*byte_idx +: 8];
                        tx_valid <= 1'b1;
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_last) begin
                            rec_valid <= 1'b0;  // free for the next error.
                            state     <= F_IDLE;
                        end
                    end
                end
                F_L_HDR: begin
                    if (!tx_valid) begin
                        tx_byte  <= mem_test_pkg::CH_LOOP;
                        tx_valid <= 1'b1;
                        state    <= F_L_CNT;
                    end
                end
                F_L_CNT: begin
                    if (!tx_valid) begin
                        tx_byte   <= loop_cnt;
                        tx_valid  <= 1'b1;
                        loop_pend <= 1'b0;
                        state     <= F_L_CR;
                    end
                end
                F_L_CR: begin
                    if (!tx_valid) begin
                        tx_byte  <= mem_test_pkg::CH_CR;
                        tx_valid <= 1'b1;
                        state    <= F_L_LF;
                    end
                end
                F_L_LF: begin
                    if (!tx_valid) begin
                        tx_byte  <= mem_test_pkg::CH_LF;
                        tx_valid <= 1'b1;
                        state    <= F_IDLE;
                    end
                end
                default: begin
                    state <= F_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_valid,
    input  logic [7:0] tx_byte,
    output logic       tx_accepted,
    output logic       txd
);

    logic                                          busy;
    logic [8:0]                                    shift;  // data bits, then stop.
    logic [3:0]                                    bit_cnt;
    logic [$clog2(mem_test_pkg::CLKS_PER_BIT)-1:0] baud_cnt;
    logic                                          bit_end;

    assign tx_accepted = tx_valid && !busy;
    assign bit_end     = (32'(baud_cnt) == mem_test_pkg::CLKS_PER_BIT - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            txd      <= 1'b1;
            bit_cnt  <= 4'd0;
            baud_cnt <= '0;
        end else if (!busy) begin
            if (tx_accepted) begin
                busy     <= 1'b1;
                txd      <= 1'b0;  // start bit.
                bit_cnt  <= 4'd0;
                baud_cnt <= '0;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
            if (bit_end) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;  // stop bit done.
                end else begin
                    txd     <= shift[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_accepted) begin
            shift <= {1'b1, tx_byte};
        end else if (busy && bit_end) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

// ==== hdl/mem_test_top.sv ====
`timescale 1ns/1ps

module mem_test_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                run,
    output logic                                mem_req,
    output mem_test_pkg::mem_cmd_t              mem_cmd,
    input  logic                                mem_ack,
    input  logic [mem_test_pkg::DATA_WIDTH-1:0] mem_rdata,
    output logic                                txd
);

    logic                     error_event;
    mem_test_pkg::error_rec_t error_rec;
    logic                     loop_done;
    logic                     tx_valid;
    logic [7:0]               tx_byte;
    logic                     tx_accepted;

    march_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .mem_req     (mem_req),
        .mem_cmd     (mem_cmd),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .error_event (error_event),
        .error_rec   (error_rec),
        .loop_done   (loop_done)
    );

    error_report u_rep (
        .clk         (clk),
        .rst         (rst),
        .error_event (error_event),
        .error_rec   (error_rec),
        .loop_done   (loop_done),
        .tx_accepted (tx_accepted),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte)
    );

    uart_tx u_tx (
        .clk         (clk),
        .rst         (rst),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte),
        .tx_accepted (tx_accepted),
        .txd         (txd)
    );

endmodule

// ==== testbench/mem_test_asserts.sv ====
`timescale 1ns/1ps

// same rules for the memory port and the uart byte input.
module mem_test_asserts (
    input logic        clk,
    input logic        rst,
    input logic        req,
    input logic        ack,
    input logic [31:0] payload
);

    hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        req && !ack |=> req && $stable(payload))
        else $error("request or payload changed before acknowledge");

    drop_after_ack: assert property (@(posedge clk) disable iff (rst)
        ack |=> !req)
        else $error("request still high the cycle after acknowledge");

    no_rise_on_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(req) |-> !$past(ack))
        else $error("request rose while acknowledge was high");

endmodule

bind march_sequencer mem_test_asserts mem_port_chk (
    .clk     (clk),
    .rst     (rst),
    .req     (mem_req),
    .ack     (mem_ack),
    .payload ({8'd0, mem_cmd})
);

bind error_report mem_test_asserts tx_port_chk (
    .clk     (clk),
    .rst     (rst),
    .req     (tx_valid),
    .ack     (tx_accepted),
    .payload ({24'd0, tx_byte})
);

// ==== testbench/tb_mem_test.sv ====
`timescale 1ns/1ps

module tb_mem_test;

    typedef logic [mem_test_pkg::DATA_WIDTH-1:0] word_t;
    typedef logic [mem_test_pkg::ADDR_WIDTH-1:0] addr_t;

    localparam int    CPB      = mem_test_pkg::CLKS_PER_BIT;
    localparam int    TIMEOUT  = 20000;  // cycles allowed per awaited byte.
    localparam word_t ONE_BIT  = 16'h0200;
    localparam word_t ZERO_BIT = 16'h0010;
    localparam word_t FLIP     = 16'h5a3c;

    logic                   clk;
    logic                   rst       = 1'b1;
    logic                   run       = 1'b0;
    logic                   mem_req;
    mem_test_pkg::mem_cmd_t mem_cmd;
    logic                   mem_ack   = 1'b0;
    word_t                  mem_rdata = '0;
    logic                   txd;

    word_t       ram [0:(1 << mem_test_pkg::ADDR_WIDTH)-1];
    addr_t       fault_addr      = '0;
    word_t       stuck_one_mask  = '0;
    word_t       stuck_zero_mask = '0;
    word_t       flip_mask       = '0;
    logic [31:0] lfsr            = 32'h07e64632;
    int          ram_state       = 0;
    int          ram_wait        = 0;
    logic        rx_busy         = 1'b0;
    int          rx_cnt          = 0;
    logic [7:0]  rx_shift        = '0;
    logic [7:0]  rx_q[$];

    mem_test_top DUT (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .txd       (txd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], 1'b0} ^ (s[31] ? 32'h0040_0007 : 32'h0);
    endfunction

    // 1 to 3 cycles from two lfsr bits.
    function automatic int draw_delay();
        int d;
        d = 0;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            d    = d * 2 + int'(lfsr[0]);
        end
        return d % 3 + 1;
    endfunction

    function automatic word_t read_word(input addr_t a);
        word_t w;
        w = ram[a] ^ flip_mask;
        if (a == fault_addr) begin
            w = (w | stuck_one_mask) & ~stuck_zero_mask;
        end
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("Fail %s expected %0h actual %0h", test, exp, act));
        end
    endtask

    always @(posedge clk) begin
        case (ram_state)
            0: begin
                if (mem_req && !mem_ack) begin
                    ram_wait  <= draw_delay();
                    ram_state <= 1;
                end
            end
            1: begin
                if (ram_wait > 1) begin
                    ram_wait <= ram_wait - 1;
                end else begin
                    if (mem_cmd.we) begin
                        ram[mem_cmd.addr] <= mem_cmd.wdata;
                    end else begin
                        mem_rdata <= read_word(mem_cmd.addr);
                    end
                    mem_ack   <= 1'b1;
                    ram_state <= 2;
                end
            end
            default: begin
                if (!mem_req) begin
                    mem_ack   <= 1'b0;  // four-phase release.
                    ram_state <= 0;
                end
            end
        endcase
    end

    // uart decoder sampling each bit at its middle.
    always @(posedge clk) begin
        if (!rx_busy) begin
            if (txd == 1'b0) begin
                rx_busy <= 1'b1;
                rx_cnt  <= 0;
            end
        end else begin
            rx_cnt <= rx_cnt + 1;
            if (rx_cnt % CPB == 0 && rx_cnt >= CPB && rx_cnt <= 8 * CPB) begin
                rx_shift <= {txd, rx_shift[7:1]};
            end
            if (rx_cnt == 9 * CPB) begin
                if (txd !== 1'b1) begin
                    abort_run("stop bit missing on the serial line");
                end
                rx_q.push_back(rx_shift);
                rx_busy <= 1'b0;
            end
        end
    end

    task automatic restart(input addr_t a, input word_t s1, input word_t s0,
                           input word_t flip, input logic go);
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        @(negedge clk);
        fault_addr      = a;
        stuck_one_mask  = s1;
        stuck_zero_mask = s0;
        flip_mask       = flip;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (20 * CPB) @(posedge clk);  // a cut-off byte drains here.
        @(negedge clk);
        rx_q.delete();
        @(posedge clk);
        run <= go;
    endtask

    task automatic get_byte(input string what, output logic [7:0] b);
        int n;
        n = 0;
        while (rx_q.size() == 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rx_q.size() == 0) begin
            abort_run($sformatf("timeout waiting for a UART byte in %s", what));
        end else begin
            b = rx_q.pop_front();
        end
    endtask

    task automatic get_word(input string test, output word_t w);
        logic [7:0] b;
        w = '0;
        for (int i = 0; i < mem_test_pkg::DATA_BYTES; i++) begin
            get_byte(test, b);
            w[8*i +: 8] = b;  // lsb first.
        end
    endtask

    task automatic expect_byte(input string test, input logic [7:0] exp);
        logic [7:0] b;
        get_byte(test, b);
        check_eq(test, 32'(exp), 32'(b));
    endtask

    task automatic expect_error_frame(input string test, input logic [7:0] ph, input addr_t a,
                                      input word_t e, input word_t act);
        word_t w;
        expect_byte(test, mem_test_pkg::CH_ERROR);
        expect_byte(test, ph);
        expect_byte(test, 8'(a));
        get_word(test, w);
        check_eq(test, 32'(e), 32'(w));
        get_word(test, w);
        check_eq(test, 32'(act), 32'(w));
    endtask

    task automatic expect_loop_frame(input string test, input logic [7:0] cnt);
        expect_byte(test, mem_test_pkg::CH_LOOP);
        expect_byte(test, cnt);
        expect_byte(test, mem_test_pkg::CH_CR);
        expect_byte(test, mem_test_pkg::CH_LF);
    endtask

    task automatic reset_idle();
        restart('0, '0, '0, '0, 1'b0);
        repeat (2000) begin
            @(negedge clk);
            check_eq("reset_idle", 32'd1, 32'(txd));
            check_eq("reset_idle", 32'd0, 32'(mem_req));
        end
    endtask

    task automatic clean_loops();
        restart('0, '0, '0, '0, 1'b1);
        repeat (2) expect_loop_frame("clean_loops", 8'd0);
    endtask

    task automatic stuck_one();
        restart(addr_t'(5), ONE_BIT, '0, '0, 1'b1);
        expect_error_frame("stuck_one", mem_test_pkg::PHASE_READ_ZERO, addr_t'(5), '0, ONE_BIT);
        expect_loop_frame("stuck_one", 8'd1);
    endtask

    task automatic stuck_zero();
        restart(addr_t'(100), '0, ZERO_BIT, '0, 1'b1);
        expect_error_frame("stuck_zero", mem_test_pkg::PHASE_READ_ONE, addr_t'(100), '1,
                           ~ZERO_BIT);
        expect_loop_frame("stuck_zero", 8'd1);
    endtask

    // every read fails, so the count saturates.
    task automatic all_fail_saturate();
        logic [7:0] b;
        logic [7:0] ph;
        logic [7:0] a;
        word_t      e;
        word_t      act;
        word_t      want;
        int         frames;
        restart('0, '0, '0, FLIP, 1'b1);
        frames = 0;
        get_byte("all_fail_saturate", b);
        while (b == mem_test_pkg::CH_ERROR && frames < 100) begin
            get_byte("all_fail_saturate", ph);
            get_byte("all_fail_saturate", a);
            get_word("all_fail_saturate", e);
            get_word("all_fail_saturate", act);
            if (frames == 0) begin
                check_eq("all_fail_saturate", 32'(mem_test_pkg::PHASE_READ_ZERO), 32'(ph));
                check_eq("all_fail_saturate", 32'd0, 32'(a));
            end
            want = (ph == mem_test_pkg::PHASE_READ_ONE) ? '1 : '0;
            check_eq("all_fail_saturate", 32'd1, 32'(ph == 8'd2 || ph == 8'd3));
            check_eq("all_fail_saturate", 32'(want), 32'(e));
            check_eq("all_fail_saturate", 32'(FLIP), 32'(e ^ act));
            frames++;
            get_byte("all_fail_saturate", b);
        end
        check_eq("all_fail_saturate", 32'd1, 32'(frames > 0));
        check_eq("all_fail_saturate", 32'(mem_test_pkg::CH_LOOP), 32'(b));
        expect_byte("all_fail_saturate", 8'd255);
        expect_byte("all_fail_saturate", mem_test_pkg::CH_CR);
        expect_byte("all_fail_saturate", mem_test_pkg::CH_LF);
    endtask

    initial begin
        reset_idle();
        clean_loops();
        stuck_one();
        stuck_zero();
        all_fail_saturate();
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== mem_test.f ====
hdl/mem_test_pkg.sv
hdl/march_sequencer.sv
hdl/error_report.sv
hdl/uart_tx.sv
hdl/mem_test_top.sv
testbench/mem_test_asserts.sv
testbench/tb_mem_test.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory tester testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mem_test \
    -f mem_test.f -o sim_mem_test
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mem_test > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
